//--- rtl/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    // Instruction field widths
    localparam int INSTR_WIDTH  = 32;
    localparam int OPCODE_WIDTH = 7;
    localparam int FUNCT3_WIDTH = 3;
    localparam int FUNCT7_WIDTH = 7;
    localparam int IMM_WIDTH    = 12;

    typedef logic [INSTR_WIDTH-1:0] instr_t;

    // Major opcodes of the RV32I slice
    typedef enum logic [OPCODE_WIDTH-1:0] {
        OP_LOAD  = 7'b0000011,
        OP_IMM   = 7'b0010011,
        OP_STORE = 7'b0100011,
        OP_REG   = 7'b0110011
    } opcode_e;

    // funct3 / funct7 codes used by the subset
    localparam logic [FUNCT3_WIDTH-1:0] F3_ADD  = 3'b000;
    localparam logic [FUNCT3_WIDTH-1:0] F3_WORD = 3'b010;
    localparam logic [FUNCT3_WIDTH-1:0] F3_XOR  = 3'b100;
    localparam logic [FUNCT3_WIDTH-1:0] F3_OR   = 3'b110;
    localparam logic [FUNCT3_WIDTH-1:0] F3_AND  = 3'b111;
    localparam logic [FUNCT7_WIDTH-1:0] F7_BASE = 7'b0000000;
    localparam logic [FUNCT7_WIDTH-1:0] F7_SUB  = 7'b0100000;

    typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR} alu_op_e;

endpackage

`default_nettype wire

//--- rtl/core_cfg_pkg.sv
`default_nettype none

package core_cfg_pkg;

    localparam int XLEN            = 32;
    localparam int REG_IDX_WIDTH   = 5;
    localparam int NUM_REGS        = 2 ** REG_IDX_WIDTH;
    localparam int IMEM_DEPTH_LOG2 = 8;
    localparam int DMEM_DEPTH_LOG2 = 8;

    typedef logic [XLEN-1:0]            word_t;
    typedef logic [REG_IDX_WIDTH-1:0]   reg_idx_t;
    typedef logic [IMEM_DEPTH_LOG2-1:0] imem_addr_t;
    typedef logic [DMEM_DEPTH_LOG2-1:0] dmem_addr_t;

    // Source of an EX operand
    typedef enum logic [1:0] {FWD_NONE, FWD_MEM, FWD_WB} fwd_sel_e;

endpackage

`default_nettype wire

//--- rtl/instr_mem.sv
`default_nettype none

module instr_mem
    import rv_isa_pkg::*;
    import core_cfg_pkg::*;
(
    input  wire             sys_clk,
    input  wire             prog_en,
    input  wire imem_addr_t prog_addr,
    input  wire instr_t     prog_data,
    input  wire imem_addr_t fetch_addr,
    output instr_t          fetch_instr
);

    instr_t mem [0:(1 << IMEM_DEPTH_LOG2) - 1];

    // Empty slots hold zero, which decodes as a no-op
    initial begin
        for (int i = 0; i < (1 << IMEM_DEPTH_LOG2); i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (prog_en) begin
            mem[prog_addr] <= prog_data;
        end
    end

    assign fetch_instr = mem[fetch_addr];

endmodule

`default_nettype wire

//--- rtl/data_mem.sv
`default_nettype none

module data_mem
    import core_cfg_pkg::*;
(
    input  wire             sys_clk,
    input  wire             wr_en,
    input  wire dmem_addr_t addr,
    input  wire word_t      wr_data,
    input  wire dmem_addr_t dbg_addr,
    output word_t           rd_data,
    output word_t           dbg_data
);

    word_t mem [0:(1 << DMEM_DEPTH_LOG2) - 1];

    // Start from a cleared memory
    initial begin
        for (int i = 0; i < (1 << DMEM_DEPTH_LOG2); i++) begin
            mem[i] = '0;
        end
    end

    // ====================
    // Pipeline port
    // ====================
    always_ff @(posedge sys_clk) begin
        if (wr_en) begin
            mem[addr] <= wr_data;
        end
    end

    assign rd_data = mem[addr];

    // ====================
    // Read-back port
    // ====================
    assign dbg_data = mem[dbg_addr];

endmodule

`default_nettype wire

//--- rtl/decoder.sv
`default_nettype none

module decoder
    import rv_isa_pkg::*;
    import core_cfg_pkg::*;
(
    input  wire instr_t instr,
    output reg_idx_t    rs1,
    output reg_idx_t    rs2,
    output reg_idx_t    rd,
    output logic        reg_write,
    output logic        mem_read,
    output logic        mem_write,
    output logic        use_imm,
    output alu_op_e     alu_op,
    output word_t       imm
);

    logic [FUNCT3_WIDTH-1:0] funct3;
    logic [FUNCT7_WIDTH-1:0] funct7;
    logic [IMM_WIDTH-1:0]    imm_i;
    logic [IMM_WIDTH-1:0]    imm_s;
    logic                    known;

    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign imm_i  = instr[31:20];
    assign imm_s  = {instr[31:25], instr[11:7]};

    always_comb begin
        rs1       = instr[19:15];
        rs2       = '0;
        rd        = instr[11:7];
        reg_write = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        use_imm   = 1'b1;
        alu_op    = ALU_ADD;
        imm       = {{(XLEN - IMM_WIDTH){imm_i[IMM_WIDTH-1]}}, imm_i};
        known     = 1'b0;

        case (instr[OPCODE_WIDTH-1:0])
            OP_REG: begin
                rs2       = instr[24:20];
                use_imm   = 1'b0;
                reg_write = 1'b1;
                known     = 1'b1;
                case ({funct7, funct3})
                    {F7_BASE, F3_ADD}: alu_op = ALU_ADD;
                    {F7_SUB, F3_ADD}:  alu_op = ALU_SUB;
                    {F7_BASE, F3_AND}: alu_op = ALU_AND;
                    {F7_BASE, F3_OR}:  alu_op = ALU_OR;
                    {F7_BASE, F3_XOR}: alu_op = ALU_XOR;
                    default:           known  = 1'b0;
                endcase
            end
            OP_IMM: begin
                // ADDI only
                reg_write = 1'b1;
                known     = (funct3 == F3_ADD);
            end
            OP_LOAD: begin
                reg_write = 1'b1;
                mem_read  = 1'b1;
                known     = (funct3 == F3_WORD);
            end
            OP_STORE: begin
                rs2       = instr[24:20];
                rd        = '0;
                mem_write = 1'b1;
                imm       = {{(XLEN - IMM_WIDTH){imm_s[IMM_WIDTH-1]}}, imm_s};
                known     = (funct3 == F3_WORD);
            end
            default: known = 1'b0;
        endcase

        // Anything outside the subset is a no-op
        if (!known) begin
            rs1       = '0;
            rs2       = '0;
            rd        = '0;
            reg_write = 1'b0;
            mem_read  = 1'b0;
            mem_write = 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- rtl/regfile.sv
`default_nettype none

module regfile
    import core_cfg_pkg::*;
(
    input  wire           sys_clk,
    input  wire           rst_n,
    input  wire           wr_en,
    input  wire reg_idx_t wr_idx,
    input  wire word_t    wr_data,
    input  wire reg_idx_t rd_idx1,
    input  wire reg_idx_t rd_idx2,
    output word_t         rd_data1,
    output word_t         rd_data2
);

    // x0 has no storage
    word_t regs [1:NUM_REGS-1];

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_idx != '0) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // Write-back value bypasses the array in the same cycle
    function automatic word_t read_port(input reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end else if (wr_en && wr_idx == idx) begin
            return wr_data;
        end
        return regs[idx];
    endfunction

    always_comb begin
        rd_data1 = read_port(rd_idx1);
        rd_data2 = read_port(rd_idx2);
    end

endmodule

`default_nettype wire

//--- rtl/forwarding_unit.sv
`default_nettype none

module forwarding_unit
    import core_cfg_pkg::*;
(
    input  wire reg_idx_t ex_rs1,
    input  wire reg_idx_t ex_rs2,
    input  wire word_t    ex_rd_data1,
    input  wire word_t    ex_rd_data2,
    input  wire           mem_reg_write,
    input  wire reg_idx_t mem_rd,
    input  wire word_t    mem_result,
    input  wire           wb_reg_write,
    input  wire reg_idx_t wb_rd,
    input  wire word_t    wb_result,
    output fwd_sel_e      fwd_sel_a,
    output fwd_sel_e      fwd_sel_b,
    output word_t         op_a,
    output word_t         op_b
);

    // Youngest producer first
    function automatic fwd_sel_e select_source(input reg_idx_t src);
        if (mem_reg_write && mem_rd != '0 && mem_rd == src) begin
            return FWD_MEM;
        end else if (wb_reg_write && wb_rd != '0 && wb_rd == src) begin
            return FWD_WB;
        end
        return FWD_NONE;
    endfunction

    function automatic word_t operand(input fwd_sel_e sel, input word_t reg_val);
        case (sel)
            FWD_MEM: return mem_result;
            FWD_WB:  return wb_result;
            default: return reg_val;
        endcase
    endfunction

    always_comb begin
        fwd_sel_a = select_source(ex_rs1);
        fwd_sel_b = select_source(ex_rs2);
        op_a      = operand(fwd_sel_a, ex_rd_data1);
        op_b      = operand(fwd_sel_b, ex_rd_data2);
    end

endmodule

`default_nettype wire

//--- rtl/hazard_unit.sv
`default_nettype none

module hazard_unit
    import core_cfg_pkg::*;
(
    input  wire reg_idx_t id_rs1,
    input  wire reg_idx_t id_rs2,
    input  wire           ex_mem_read,
    input  wire reg_idx_t ex_rd,
    output logic          stall
);

    logic rd_live;
    logic src_match;

    // Unused sources arrive as x0 and never match
    assign rd_live   = ex_mem_read && (ex_rd != '0);
    assign src_match = (ex_rd == id_rs1) || (ex_rd == id_rs2);

    // Load result is not ready before EX of the next instruction
    assign stall = rd_live && src_match;

endmodule

`default_nettype wire

//--- rtl/alu.sv
`default_nettype none

module alu
    import rv_isa_pkg::*;
    import core_cfg_pkg::*;
(
    input  wire alu_op_e op,
    input  wire word_t   a,
    input  wire word_t   b,
    output word_t        result
);

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/core.sv
`default_nettype none

module core
    import rv_isa_pkg::*;
    import core_cfg_pkg::*;
(
    input  wire             sys_clk,
    input  wire             rst_n,
    input  wire             running,
    input  wire             prog_en,
    input  wire imem_addr_t prog_addr,
    input  wire instr_t     prog_data,
    input  wire dmem_addr_t dbg_addr,
    output word_t           dbg_data,
    output logic            retire_valid,
    output reg_idx_t        retire_rd,
    output word_t           retire_data
);

    imem_addr_t pc;
    instr_t     fetch_instr;
    logic       load_stall;

    logic       id_valid;
    instr_t     id_instr;
    reg_idx_t   id_rs1, id_rs2, id_rd;
    logic       id_reg_write, id_mem_read, id_mem_write, id_use_imm;
    alu_op_e    id_alu_op;
    word_t      id_imm, id_rd_data1, id_rd_data2;

    logic       ex_valid, ex_reg_write, ex_mem_read, ex_mem_write, ex_use_imm;
    alu_op_e    ex_alu_op;
    reg_idx_t   ex_rs1, ex_rs2, ex_rd;
    word_t      ex_rd_data1, ex_rd_data2, ex_imm;
    word_t      ex_op_a, ex_op_b, ex_alu_result;

    logic       mem_valid, mem_reg_write, mem_mem_read, mem_mem_write;
    reg_idx_t   mem_rd;
    word_t      mem_alu_result, mem_store_data, mem_load_data, mem_result;

    logic       wb_valid, wb_reg_write;
    reg_idx_t   wb_rd;
    word_t      wb_result;

    // Control qualified by the stage valid bits
    logic       ex_is_load, mem_writes_reg, wb_writes_reg;

    assign ex_is_load     = ex_valid & ex_mem_read;
    assign mem_writes_reg = mem_valid & mem_reg_write;
    assign wb_writes_reg  = wb_valid & wb_reg_write;

    // ====================
    // IF
    // ====================
    instr_mem imem_i (
        .sys_clk(sys_clk),
        .prog_en(prog_en),
        .prog_addr(prog_addr),
        .prog_data(prog_data),
        .fetch_addr(pc),
        .fetch_instr(fetch_instr)
    );

    // PC and IF/ID hold on a load-use stall
    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            pc       <= '0;
            id_valid <= 1'b0;
        end else if (running && !load_stall) begin
            pc       <= pc + imem_addr_t'(1);
            id_valid <= 1'b1;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (running && !load_stall) begin
            id_instr <= fetch_instr;
        end
    end

    // ====================
    // ID
    // ====================
    decoder dec_i (
        .instr(id_instr),
        .rs1(id_rs1),
        .rs2(id_rs2),
        .rd(id_rd),
        .reg_write(id_reg_write),
        .mem_read(id_mem_read),
        .mem_write(id_mem_write),
        .use_imm(id_use_imm),
        .alu_op(id_alu_op),
        .imm(id_imm)
    );

    regfile rf_i (
        .sys_clk(sys_clk),
        .rst_n(rst_n),
        .wr_en(running & wb_writes_reg),
        .wr_idx(wb_rd),
        .wr_data(wb_result),
        .rd_idx1(id_rs1),
        .rd_idx2(id_rs2),
        .rd_data1(id_rd_data1),
        .rd_data2(id_rd_data2)
    );

    hazard_unit hzd_i (
        .id_rs1(id_rs1),
        .id_rs2(id_rs2),
        .ex_mem_read(ex_is_load),
        .ex_rd(ex_rd),
        .stall(load_stall)
    );

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            ex_valid     <= 1'b0;
            ex_reg_write <= 1'b0;
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
        end else if (running) begin
            // Bubble into EX while the load resolves
            ex_valid     <= id_valid & ~load_stall;
            ex_reg_write <= id_reg_write;
            ex_mem_read  <= id_mem_read;
            ex_mem_write <= id_mem_write;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (running) begin
            ex_use_imm  <= id_use_imm;
            ex_alu_op   <= id_alu_op;
            ex_rs1      <= id_rs1;
            ex_rs2      <= id_rs2;
            ex_rd       <= id_rd;
            ex_rd_data1 <= id_rd_data1;
            ex_rd_data2 <= id_rd_data2;
            ex_imm      <= id_imm;
        end
    end

    // ====================
    // EX
    // ====================
    forwarding_unit fwd_i (
        .ex_rs1(ex_rs1),
        .ex_rs2(ex_rs2),
        .ex_rd_data1(ex_rd_data1),
        .ex_rd_data2(ex_rd_data2),
        .mem_reg_write(mem_writes_reg),
        .mem_rd(mem_rd),
        .mem_result(mem_result),
        .wb_reg_write(wb_writes_reg),
        .wb_rd(wb_rd),
        .wb_result(wb_result),
        .fwd_sel_a(),
        .fwd_sel_b(),
        .op_a(ex_op_a),
        .op_b(ex_op_b)
    );

    alu alu_i (
        .op(ex_alu_op),
        .a(ex_op_a),
        .b(ex_use_imm ? ex_imm : ex_op_b),
        .result(ex_alu_result)
    );

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            mem_valid     <= 1'b0;
            mem_reg_write <= 1'b0;
            mem_mem_read  <= 1'b0;
            mem_mem_write <= 1'b0;
        end else if (running) begin
            mem_valid     <= ex_valid;
            mem_reg_write <= ex_reg_write;
            mem_mem_read  <= ex_mem_read;
            mem_mem_write <= ex_mem_write;
        end
    end

    // Forwarded rs2 doubles as store data
    always_ff @(posedge sys_clk) begin
        if (running) begin
            mem_rd         <= ex_rd;
            mem_alu_result <= ex_alu_result;
            mem_store_data <= ex_op_b;
        end
    end

    // ====================
    // MEM / WB
    // ====================
    data_mem dmem_i (
        .sys_clk(sys_clk),
        .wr_en(running & mem_valid & mem_mem_write),
        .addr(mem_alu_result[DMEM_DEPTH_LOG2+1:2]),
        .wr_data(mem_store_data),
        .dbg_addr(dbg_addr),
        .rd_data(mem_load_data),
        .dbg_data(dbg_data)
    );

    assign mem_result = mem_mem_read ? mem_load_data : mem_alu_result;

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            wb_valid     <= 1'b0;
            wb_reg_write <= 1'b0;
        end else if (running) begin
            wb_valid     <= mem_valid;
            wb_reg_write <= mem_reg_write;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (running) begin
            wb_rd     <= mem_rd;
            wb_result <= mem_result;
        end
    end

    // One pulse per register write, since MEM/WB moves every running cycle
    assign retire_valid = running & wb_writes_reg & (wb_rd != '0);
    assign retire_rd    = wb_rd;
    assign retire_data  = wb_result;

endmodule

`default_nettype wire

//--- dv/core_chk.sv
`default_nettype none

module core_chk (
    input wire sys_clk,
    input wire rst_n,
    input wire running,
    input wire retire_valid,
    input wire load_stall
);

    // Retire port quiet in reset
    property retire_quiet_in_reset;
        @(posedge sys_clk) !rst_n |-> !retire_valid;
    endproperty

    // Frozen core retires nothing
    property retire_quiet_when_frozen;
        @(posedge sys_clk) !running |-> !retire_valid;
    endproperty

    // One bubble per load-use pair
    property stall_single_cycle;
        @(posedge sys_clk) disable iff (!rst_n)
            (running && load_stall) |=> !(running && load_stall);
    endproperty

    retire_reset_a: assert property (retire_quiet_in_reset)
        else $error("retire_valid high during reset");

    retire_frozen_a: assert property (retire_quiet_when_frozen)
        else $error("retire_valid high while running is low");

    stall_single_a: assert property (stall_single_cycle)
        else $error("load-use stall held for two running cycles");

endmodule

bind core core_chk core_chk_i (
    .sys_clk(sys_clk),
    .rst_n(rst_n),
    .running(running),
    .retire_valid(retire_valid),
    .load_stall(load_stall)
);

`default_nettype wire

//--- dv/core_tb.sv
`default_nettype none

module core_tb
    import rv_isa_pkg::*;
    import core_cfg_pkg::*;
;

    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DELAY  = 2;
    localparam int RESET_CYCLES = 16;
    localparam int NOP_PAD      = 3;
    localparam word_t LCG_SEED  = 32'h4455c3af;

    // Program lengths of the directed tests
    localparam int LEN_ALU   = 16;
    localparam int LEN_FWD   = 12;
    localparam int LEN_MEM   = 16;
    localparam int LEN_PAUSE = 12;
    localparam int LEN_ZERO  = 6;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + 6 * 40
        + 4 * (LEN_ALU + LEN_FWD + LEN_MEM + LEN_PAUSE + LEN_ZERO);

    typedef enum {K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_ADDI, K_LW, K_SW} kind_e;

    logic       sys_clk;
    logic       rst_n;
    logic       running;
    logic       prog_en;
    imem_addr_t prog_addr;
    instr_t     prog_data;
    dmem_addr_t dbg_addr;
    word_t      dbg_data;
    logic       retire_valid;
    reg_idx_t   retire_rd;
    word_t      retire_data;

    int         cycle_count;
    word_t      lcg_state;

    // Program under test and its expected results
    kind_e      p_kind [$];
    reg_idx_t   p_rd [$];
    reg_idx_t   p_rs1 [$];
    reg_idx_t   p_rs2 [$];
    word_t      p_imm [$];
    reg_idx_t   exp_rd [$];
    word_t      exp_data [$];
    dmem_addr_t st_addr [$];
    word_t      model_regs [0:NUM_REGS-1];
    word_t      model_mem [0:(1 << DMEM_DEPTH_LOG2) - 1];

    core core_i (
        .sys_clk(sys_clk),
        .rst_n(rst_n),
        .running(running),
        .prog_en(prog_en),
        .prog_addr(prog_addr),
        .prog_data(prog_data),
        .dbg_addr(dbg_addr),
        .dbg_data(dbg_data),
        .retire_valid(retire_valid),
        .retire_rd(retire_rd),
        .retire_data(retire_data)
    );

    initial begin
        sys_clk = 1'b0;
        forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge sys_clk);
            cycle_count++;
        end
        report_failure($sformatf("Timeout: the tests did not finish within %0d cycles",
                                 TIMEOUT_CYCLES));
    end

    // ====================
    // Helpers
    // ====================
    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped on the first failure");
    endtask

    task automatic check_word(input string test, input string what, input word_t expected,
                              input word_t actual);
        if (actual !== expected) begin
            report_failure($sformatf("[ERROR] %s: %s expected %08h actual %08h",
                                     test, what, expected, actual));
        end
    endtask

    task automatic check_reg_idx(input string test, input string what, input reg_idx_t expected,
                                 input reg_idx_t actual);
        if (actual !== expected) begin
            report_failure($sformatf("[ERROR] %s: %s expected x%0d actual x%0d",
                                     test, what, expected, actual));
        end
    endtask

    task automatic next_cycle();
        @(posedge sys_clk);
        #DRIVE_DELAY;
    endtask

    function automatic word_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Signed 12-bit immediate
    function automatic word_t rand_imm();
        word_t r;
        r = lcg_next();
        return {{20{r[11]}}, r[11:0]};
    endfunction

    // RV32I encodings of the subset
    function automatic instr_t encode(input kind_e kind, input reg_idx_t rd, input reg_idx_t rs1,
                                      input reg_idx_t rs2, input word_t imm);
        case (kind)
            K_ADD:   return {7'b0000000, rs2, rs1, 3'b000, rd, OP_REG};
            K_SUB:   return {7'b0100000, rs2, rs1, 3'b000, rd, OP_REG};
            K_AND:   return {7'b0000000, rs2, rs1, 3'b111, rd, OP_REG};
            K_OR:    return {7'b0000000, rs2, rs1, 3'b110, rd, OP_REG};
            K_XOR:   return {7'b0000000, rs2, rs1, 3'b100, rd, OP_REG};
            K_ADDI:  return {imm[11:0], rs1, 3'b000, rd, OP_IMM};
            K_LW:    return {imm[11:0], rs1, 3'b010, rd, OP_LOAD};
            K_SW:    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
            default: return '0;
        endcase
    endfunction

    task automatic clear_program();
        p_kind.delete();
        p_rd.delete();
        p_rs1.delete();
        p_rs2.delete();
        p_imm.delete();
    endtask

    task automatic add_instr(input kind_e kind, input int rd, input int rs1, input int rs2,
                             input word_t imm);
        p_kind.push_back(kind);
        p_rd.push_back(reg_idx_t'(rd));
        p_rs1.push_back(reg_idx_t'(rs1));
        p_rs2.push_back(reg_idx_t'(rs2));
        p_imm.push_back(imm);
    endtask

    // Sequential execution of the program, one instruction at a time
    task automatic run_model();
        word_t      a;
        word_t      b;
        word_t      res;
        word_t      addr_b;
        dmem_addr_t widx;
        logic       writes;
        exp_rd.delete();
        exp_data.delete();
        st_addr.delete();
        for (int k = 0; k < NUM_REGS; k++) begin
            model_regs[k] = '0;
        end
        for (int i = 0; i < p_kind.size(); i++) begin
            a      = model_regs[p_rs1[i]];
            b      = model_regs[p_rs2[i]];
            addr_b = a + p_imm[i];
            widx   = addr_b[DMEM_DEPTH_LOG2+1:2];
            writes = 1'b1;
            res    = '0;
            case (p_kind[i])
                K_ADD:  res = a + b;
                K_SUB:  res = a - b;
                K_AND:  res = a & b;
                K_OR:   res = a | b;
                K_XOR:  res = a ^ b;
                K_ADDI: res = a + p_imm[i];
                K_LW:   res = model_mem[widx];
                default: begin
                    model_mem[widx] = b;
                    st_addr.push_back(widx);
                    writes = 1'b0;
                end
            endcase
            if (writes && p_rd[i] != '0) begin
                model_regs[p_rd[i]] = res;
                exp_rd.push_back(p_rd[i]);
                exp_data.push_back(res);
            end
        end
    endtask

    // Second half of reset runs the core so only reset keeps the retire port quiet
    task automatic apply_reset();
        rst_n   = 1'b0;
        running = 1'b0;
        repeat (RESET_CYCLES / 2) next_cycle();
        running = 1'b1;
        repeat (RESET_CYCLES - RESET_CYCLES / 2) next_cycle();
        running = 1'b0;
        rst_n   = 1'b1;
    endtask

    // Trailing no-ops keep leftovers of older programs out of the pipeline
    task automatic load_program();
        prog_en = 1'b1;
        for (int i = 0; i < p_kind.size() + NOP_PAD; i++) begin
            prog_addr = imem_addr_t'(i);
            if (i < p_kind.size()) begin
                prog_data = encode(p_kind[i], p_rd[i], p_rs1[i], p_rs2[i], p_imm[i]);
            end else begin
                prog_data = '0;
            end
            next_cycle();
        end
        prog_en = 1'b0;
    endtask

    task automatic check_memory(input string test);
        for (int i = 0; i < st_addr.size(); i++) begin
            dbg_addr = st_addr[i];
            @(negedge sys_clk);
            check_word(test, $sformatf("dbg_data[%0d]", st_addr[i]),
                       model_mem[st_addr[i]], dbg_data);
            next_cycle();
        end
    endtask

    // A negative pause_at runs without a pause
    task automatic run_program(input string test, input int pause_at, input int pause_len);
        int got;
        int cyc;
        got = 0;
        cyc = 0;
        apply_reset();
        load_program();
        run_model();
        running = 1'b1;
        while (got < exp_rd.size()) begin
            @(negedge sys_clk);
            if (retire_valid) begin
                check_reg_idx(test, "retire_rd", exp_rd[got], retire_rd);
                check_word(test, "retire_data", exp_data[got], retire_data);
                got++;
            end
            next_cycle();
            cyc++;
            if (cyc == pause_at) begin
                running = 1'b0;
                repeat (pause_len) begin
                    @(negedge sys_clk);
                    if (retire_valid) begin
                        report_failure($sformatf("%s: retire_valid rose while paused", test));
                    end
                    next_cycle();
                end
                running = 1'b1;
            end
        end
        running = 1'b0;
        check_memory(test);
    endtask

    // ====================
    // Directed tests
    // ====================
    task automatic test_reset_freeze();
        repeat (20) begin
            @(negedge sys_clk);
            if (retire_valid) begin
                report_failure("reset_freeze: retire_valid rose while the core was frozen");
            end
            next_cycle();
        end
        for (int k = 0; k < 4; k++) begin
            dbg_addr = dmem_addr_t'(k * 85);
            @(negedge sys_clk);
            check_word("reset_freeze", "dbg_data", '0, dbg_data);
            next_cycle();
        end
    endtask

    task automatic test_independent_alu();
        kind_e ops [5];
        ops = '{K_ADD, K_SUB, K_AND, K_OR, K_XOR};
        clear_program();
        for (int k = 1; k <= 8; k++) begin
            add_instr(K_ADDI, k, 0, 0, rand_imm());
        end
        // Sources are at least four instructions old
        for (int k = 0; k < 8; k++) begin
            add_instr(ops[k % 5], 9 + k, 1 + (k % 4), 5 + (k % 4), '0);
        end
        run_program("independent_alu", -1, 0);
    endtask

    task automatic test_forwarding();
        clear_program();
        add_instr(K_ADDI, 1, 0, 0, rand_imm());
        add_instr(K_ADDI, 2, 0, 0, rand_imm());
        add_instr(K_ADDI, 3, 0, 0, rand_imm());
        add_instr(K_ADD,  4, 3, 2, '0);
        add_instr(K_SUB,  5, 4, 1, '0);
        add_instr(K_XOR,  6, 5, 4, '0);
        add_instr(K_OR,   7, 6, 4, '0);
        add_instr(K_AND,  8, 7, 5, '0);
        add_instr(K_ADDI, 9, 8, 0, rand_imm());
        // Back-to-back writes of x9 where the younger value must win
        add_instr(K_ADDI, 9, 9, 0, rand_imm());
        add_instr(K_ADD,  10, 9, 8, '0);
        add_instr(K_SUB,  11, 10, 9, '0);
        run_program("forwarding", -1, 0);
    endtask

    task automatic test_memory_load_use();
        clear_program();
        add_instr(K_ADDI, 1, 0, 0, 64);
        add_instr(K_ADDI, 2, 0, 0, rand_imm());
        add_instr(K_ADDI, 3, 0, 0, rand_imm());
        add_instr(K_ADD,  4, 2, 3, '0);
        add_instr(K_SW,   0, 1, 2, 0);
        add_instr(K_SW,   0, 1, 4, 4);
        add_instr(K_SW,   0, 1, 3, 8);
        add_instr(K_LW,   5, 1, 0, 0);
        add_instr(K_ADD,  6, 5, 3, '0);
        add_instr(K_LW,   7, 1, 0, 4);
        add_instr(K_ADD,  8, 7, 7, '0);
        add_instr(K_LW,   9, 1, 0, 8);
        add_instr(K_SUB,  10, 9, 6, '0);
        add_instr(K_SW,   0, 1, 10, 12);
        add_instr(K_LW,   11, 1, 0, 12);
        add_instr(K_XOR,  12, 11, 1, '0);
        run_program("memory_load_use", -1, 0);
    endtask

    task automatic test_pause();
        clear_program();
        add_instr(K_ADDI, 1, 0, 0, rand_imm());
        add_instr(K_ADDI, 2, 1, 0, rand_imm());
        add_instr(K_ADD,  3, 2, 1, '0);
        add_instr(K_SW,   0, 0, 3, 32);
        add_instr(K_LW,   4, 0, 0, 32);
        add_instr(K_SUB,  5, 4, 3, '0);
        add_instr(K_XOR,  6, 5, 2, '0);
        add_instr(K_ADDI, 7, 6, 0, rand_imm());
        add_instr(K_OR,   8, 7, 5, '0);
        add_instr(K_AND,  9, 8, 7, '0);
        add_instr(K_ADD,  10, 9, 4, '0);
        add_instr(K_SUB,  11, 10, 1, '0);
        run_program("pause", 6, 5);
    endtask

    task automatic test_register_zero();
        clear_program();
        add_instr(K_ADDI, 0, 0, 0, rand_imm());
        add_instr(K_ADDI, 1, 0, 0, rand_imm());
        add_instr(K_ADD,  0, 1, 1, '0);
        add_instr(K_ADD,  2, 0, 1, '0);
        add_instr(K_LW,   0, 0, 0, 0);
        add_instr(K_SUB,  3, 2, 0, '0);
        run_program("register_zero", -1, 0);
    endtask

    initial begin
        rst_n     = 1'b0;
        running   = 1'b0;
        prog_en   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        dbg_addr  = '0;
        lcg_state = LCG_SEED;
        for (int k = 0; k < (1 << DMEM_DEPTH_LOG2); k++) begin
            model_mem[k] = '0;
        end
        apply_reset();
        test_reset_freeze();
        test_independent_alu();
        test_forwarding();
        test_memory_load_use();
        test_pause();
        test_register_zero();
        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
rtl/rv_isa_pkg.sv
rtl/core_cfg_pkg.sv
rtl/instr_mem.sv
rtl/data_mem.sv
rtl/decoder.sv
rtl/regfile.sv
rtl/forwarding_unit.sv
rtl/hazard_unit.sv
rtl/alu.sv
rtl/core.sv
dv/core_chk.sv
dv/core_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -eo pipefail
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module core_tb -f compile.f -o sim_core
./obj_dir/sim_core 2>&1 | tee sim.log

if grep -qx "=== PASS ===" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
